// ==== hw/al_cfg_pkg.sv ====
package al_cfg_pkg;

  // default number of active list entries
  localparam int AL_DEPTH = 16;

  // index width, enough for any legal depth
  localparam int AL_INDEX = 4;

  // occupancy counter needs one extra bit to hold a full list
  localparam int CNT_W = AL_INDEX + 1;

  // destination physical register tag
  localparam int TAG_W = 7;

  // program counter
  localparam int PC_W = 32;

  // retirement lanes per cycle
  localparam int DEF_COMMIT_WIDTH = 2;

  // completion lanes per cycle
  localparam int DEF_COMPLETE_WIDTH = 3;

endpackage

// ==== hw/al_types_pkg.sv ====
package al_types_pkg;

  import al_cfg_pkg::*;

  // list index
  typedef logic [AL_INDEX-1:0] al_idx_t;

  // what is stored per entry until retirement
  typedef struct packed {
    logic [TAG_W-1:0] dest_tag;
    logic [PC_W-1:0]  pc;
  } al_payload_t;

  // one dispatch strobe from rename
  typedef struct packed {
    logic        valid;
    al_payload_t payload;
  } dispatch_t;

  // completion lane from the execute side
  typedef struct packed {
    logic    valid;
    al_idx_t idx;
  } complete_t;

  // one retiring instruction
  typedef struct packed {
    logic        valid;
    al_idx_t     idx;
    al_payload_t payload;
  } commit_t;

endpackage

// ==== hw/al_ready_ram.sv ====
`timescale 1ns/1ns

module al_ready_ram
  import al_cfg_pkg::*;
  import al_types_pkg::*;
#(
  parameter int DEPTH          = AL_DEPTH,
  parameter int COMMIT_WIDTH   = DEF_COMMIT_WIDTH,
  parameter int COMPLETE_WIDTH = DEF_COMPLETE_WIDTH
)
(
  input  logic                                clk,
  input  logic                                reset,
  // head window reads
  input  al_idx_t   [COMMIT_WIDTH-1:0]        rd_idx_i,
  output logic      [COMMIT_WIDTH-1:0]        rd_ready_o,
  // completion set ports
  input  complete_t [COMPLETE_WIDTH-1:0]      complete_i,
  // commit clear ports
  input  logic      [COMMIT_WIDTH-1:0]        clr_en_i,
  input  al_idx_t   [COMMIT_WIDTH-1:0]        clr_idx_i
);

  // one ready bit per entry
  logic [DEPTH-1:0] ready_q;

  // asynchronous reads, one per commit lane
  always_comb
  begin
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      rd_ready_o[k] = ready_q[rd_idx_i[k]];
    end
  end

  // all write ports land in one block
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ready_q <= '0;
    end
    else
    begin
      // completions mark entries ready
      for (int w = 0; w < COMPLETE_WIDTH; w++)
      begin
        if (complete_i[w].valid)
        begin
          ready_q[complete_i[w].idx] <= 1'b1;
        end
      end
      // retired entries drop their bit so a reused slot starts clean
      for (int c = 0; c < COMMIT_WIDTH; c++)
      begin
        if (clr_en_i[c])
        begin
          ready_q[clr_idx_i[c]] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hw/al_payload_ram.sv ====
`timescale 1ns/1ns

module al_payload_ram
  import al_cfg_pkg::*;
  import al_types_pkg::*;
#(
  parameter int DEPTH        = AL_DEPTH,
  parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
)
(
  input  logic                              clk,
  // dispatch write at the tail
  input  logic                              wr_en_i,
  input  al_idx_t                           wr_idx_i,
  input  al_payload_t                       wr_data_i,
  // head window reads
  input  al_idx_t     [COMMIT_WIDTH-1:0]    rd_idx_i,
  output al_payload_t [COMMIT_WIDTH-1:0]    rd_data_o
);

  // payload storage, one word per entry
  al_payload_t mem [DEPTH];

  // single write port from dispatch
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      mem[wr_idx_i] <= wr_data_i;
    end
  end

  // combinational reads of the oldest entries
  always_comb
  begin
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      rd_data_o[k] = mem[rd_idx_i[k]];
    end
  end

endmodule

// ==== hw/al_ctrl.sv ====
`timescale 1ns/1ns

module al_ctrl
  import al_cfg_pkg::*;
  import al_types_pkg::*;
#(
  parameter int DEPTH        = AL_DEPTH,
  parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
)
(
  input  logic                              clk,
  input  logic                              reset,
  // dispatch side
  input  dispatch_t                         dispatch_i,
  output al_idx_t                           alloc_idx_o,
  output logic                              full_o,
  output logic                              empty_o,
  // head window to both RAMs
  output al_idx_t     [COMMIT_WIDTH-1:0]    rd_idx_o,
  input  logic        [COMMIT_WIDTH-1:0]    rd_ready_i,
  input  al_payload_t [COMMIT_WIDTH-1:0]    rd_data_i,
  // retirement
  output commit_t     [COMMIT_WIDTH-1:0]    commit_o,
  output logic        [COMMIT_WIDTH-1:0]    clr_en_o,
  output al_idx_t     [COMMIT_WIDTH-1:0]    clr_idx_o,
  // payload write at the tail
  output logic                              pay_wr_en_o,
  output al_idx_t                           pay_wr_idx_o
);

  // wrap mask, depth is a power of two
  localparam al_idx_t IDX_MASK = AL_INDEX'(DEPTH - 1);

  // oldest entry, next free slot, occupancy
  al_idx_t          head_q;
  al_idx_t          tail_q;
  logic [CNT_W-1:0] count_q;

  logic                    dispatch_ok;
  logic [COMMIT_WIDTH-1:0] lane_occ;
  logic [COMMIT_WIDTH-1:0] commit_en;
  logic [CNT_W-1:0]        retire_cnt;

  // status levels straight from the counter
  assign full_o      = (count_q == CNT_W'(DEPTH));
  assign empty_o     = (count_q == '0);
  assign alloc_idx_o = tail_q;

  // a strobe while full is dropped
  assign dispatch_ok  = dispatch_i.valid & ~full_o;
  assign pay_wr_en_o  = dispatch_ok;
  assign pay_wr_idx_o = tail_q;

  // head window, lane k looks at head + k
  always_comb
  begin
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      rd_idx_o[k] = (head_q + AL_INDEX'(k)) & IDX_MASK;
      // only lanes inside the occupied region may retire
      lane_occ[k] = (CNT_W'(k) < count_q);
    end
  end

  // longest ready run starting at lane 0
  always_comb
  begin
    logic run;
    run        = 1'b1;
    retire_cnt = '0;
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      // one stalled lane blocks every younger lane
      run          = run & lane_occ[k] & rd_ready_i[k];
      commit_en[k] = run;
      retire_cnt   = retire_cnt + CNT_W'(run);
    end
  end

  // commit lanes carry index and payload of the window
  always_comb
  begin
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      commit_o[k].valid   = commit_en[k];
      commit_o[k].idx     = rd_idx_o[k];
      commit_o[k].payload = rd_data_i[k];
    end
  end

  // clear the ready bits of what retires this cycle
  assign clr_en_o  = commit_en;
  assign clr_idx_o = rd_idx_o;

  // pointer and counter update
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end
    else
    begin
      // retire_cnt never exceeds depth, low bits give the wrap
      head_q <= (head_q + retire_cnt[AL_INDEX-1:0]) & IDX_MASK;
      if (dispatch_ok)
      begin
        tail_q <= (tail_q + 1'b1) & IDX_MASK;
      end
      // dispatch and retirements in one step
      count_q <= count_q + CNT_W'(dispatch_ok) - retire_cnt;
    end
  end

endmodule

// ==== hw/active_list.sv ====
`timescale 1ns/1ns

module active_list
  import al_cfg_pkg::*;
  import al_types_pkg::*;
#(
  parameter int DEPTH          = AL_DEPTH,
  parameter int COMMIT_WIDTH   = DEF_COMMIT_WIDTH,
  parameter int COMPLETE_WIDTH = DEF_COMPLETE_WIDTH
)
(
  input  logic                              clk,
  input  logic                              reset,
  input  dispatch_t                         dispatch_i,
  input  complete_t   [COMPLETE_WIDTH-1:0]  complete_i,
  output al_idx_t                           alloc_idx_o,
  output commit_t     [COMMIT_WIDTH-1:0]    commit_o,
  output logic                              full_o,
  output logic                              empty_o
);

  // head window shared by both RAMs
  al_idx_t     [COMMIT_WIDTH-1:0] rd_idx;
  logic        [COMMIT_WIDTH-1:0] rd_ready;
  al_payload_t [COMMIT_WIDTH-1:0] rd_data;

  // ready bit clears on retirement
  logic        [COMMIT_WIDTH-1:0] clr_en;
  al_idx_t     [COMMIT_WIDTH-1:0] clr_idx;

  // payload write at the tail
  logic    pay_wr_en;
  al_idx_t pay_wr_idx;

  // pointers, prefix select, commit lanes
  al_ctrl #(
    .DEPTH        (DEPTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_al_ctrl (
    .clk          (clk),
    .reset        (reset),
    .dispatch_i   (dispatch_i),
    .alloc_idx_o  (alloc_idx_o),
    .full_o       (full_o),
    .empty_o      (empty_o),
    .rd_idx_o     (rd_idx),
    .rd_ready_i   (rd_ready),
    .rd_data_i    (rd_data),
    .commit_o     (commit_o),
    .clr_en_o     (clr_en),
    .clr_idx_o    (clr_idx),
    .pay_wr_en_o  (pay_wr_en),
    .pay_wr_idx_o (pay_wr_idx)
  );

  // completion lanes go straight to the set ports
  al_ready_ram #(
    .DEPTH          (DEPTH),
    .COMMIT_WIDTH   (COMMIT_WIDTH),
    .COMPLETE_WIDTH (COMPLETE_WIDTH)
  ) u_al_ready_ram (
    .clk        (clk),
    .reset      (reset),
    .rd_idx_i   (rd_idx),
    .rd_ready_o (rd_ready),
    .complete_i (complete_i),
    .clr_en_i   (clr_en),
    .clr_idx_i  (clr_idx)
  );

  // dest tag and pc per entry
  al_payload_ram #(
    .DEPTH        (DEPTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_al_payload_ram (
    .clk       (clk),
    .wr_en_i   (pay_wr_en),
    .wr_idx_i  (pay_wr_idx),
    .wr_data_i (dispatch_i.payload),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data)
  );

endmodule

// ==== sim/al_ctrl_asserts.sv ====
`timescale 1ns/1ns

module al_ctrl_asserts
  import al_cfg_pkg::*;
#(
  parameter int DEPTH        = AL_DEPTH,
  parameter int COMMIT_WIDTH = DEF_COMMIT_WIDTH
)
(
  input logic                    clk,
  input logic                    reset,
  input logic [CNT_W-1:0]        count_i,
  input logic                    empty_i,
  input logic [COMMIT_WIDTH-1:0] commit_en_i
);

  // failures seen so far, read at the end of the run
  int fail_count = 0;

  logic [COMMIT_WIDTH-1:0] lane_inc;

  // a prefix looks like 0..01..1, adding one clears every set bit
  assign lane_inc = commit_en_i + 1'b1;

  count_bound: assert property (@(posedge clk) disable iff (reset) count_i <= CNT_W'(DEPTH))
  else
  begin
    fail_count++;
    $error("occupancy count above depth");
  end

  // no lane may commit past a stalled older lane
  commit_prefix: assert property (@(posedge clk) disable iff (reset)
    (commit_en_i & lane_inc) == '0)
  else
  begin
    fail_count++;
    $error("commit lanes are not a contiguous prefix");
  end

  empty_quiet: assert property (@(posedge clk) disable iff (reset)
    empty_i |-> commit_en_i == '0)
  else
  begin
    fail_count++;
    $error("commit lane valid while the list is empty");
  end

endmodule

bind al_ctrl al_ctrl_asserts #(
  .DEPTH        (DEPTH),
  .COMMIT_WIDTH (COMMIT_WIDTH)
) u_al_ctrl_asserts (
  .clk         (clk),
  .reset       (reset),
  .count_i     (count_q),
  .empty_i     (empty_o),
  .commit_en_i (commit_en)
);

// ==== sim/al_checker.sv ====
`timescale 1ns/1ns

module al_checker
  import al_cfg_pkg::*;
  import al_types_pkg::*;
#(
  parameter int DEPTH          = AL_DEPTH,
  parameter int COMMIT_WIDTH   = DEF_COMMIT_WIDTH,
  parameter int COMPLETE_WIDTH = DEF_COMPLETE_WIDTH
)
(
  input  logic                           clk,
  input  logic                           reset,
  input  dispatch_t                      dispatch_i,
  input  complete_t [COMPLETE_WIDTH-1:0] complete_i,
  input  al_idx_t                        alloc_idx_i,
  input  commit_t   [COMMIT_WIDTH-1:0]   commit_i,
  input  logic                           full_i,
  input  logic                           empty_i,
  output int                             errors_o
);

  typedef commit_t [COMMIT_WIDTH-1:0] commit_vec_t;

  // in-flight entries, oldest first
  // valid field holds the ready flag here
  commit_t model_q [$];
  al_idx_t model_tail;
  int      errors = 0;

  assign errors_o = errors;

  // expected lanes: ready run from the oldest entry, capped at commit width
  function automatic commit_vec_t predict_commit();
    commit_vec_t want;
    want = '0;
    for (int k = 0; k < COMMIT_WIDTH; k++)
    begin
      if (k >= model_q.size() || !model_q[k].valid)
        break;
      want[k] = model_q[k];
    end
    return want;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    errors++;
    $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, want);
  endtask

  // apply what the DUT sampled at this edge
  always @(posedge clk)
  begin
    commit_vec_t retire;
    logic        was_full;
    if (reset)
    begin
      model_q.delete();
      model_tail = '0;
    end
    else
    begin
      retire   = predict_commit();
      was_full = (model_q.size() == DEPTH);
      // retirements leave from the front
      for (int k = 0; k < COMMIT_WIDTH; k++)
      begin
        if (retire[k].valid)
          void'(model_q.pop_front());
      end
      // completions only name entries still in flight
      foreach (model_q[e])
      begin
        for (int w = 0; w < COMPLETE_WIDTH; w++)
        begin
          if (complete_i[w].valid && complete_i[w].idx == model_q[e].idx)
            model_q[e].valid = 1'b1;
        end
      end
      // strobe against a full list is dropped
      if (dispatch_i.valid && !was_full)
      begin
        model_q.push_back({1'b0, model_tail, dispatch_i.payload});
        model_tail = al_idx_t'((int'(model_tail) + 1) % DEPTH);
      end
    end
  end

  // outputs settled by mid cycle
  always @(negedge clk)
  begin
    commit_vec_t want;
    if (!reset)
    begin
      want = predict_commit();
      // idx and payload only matter on a valid lane
      for (int k = 0; k < COMMIT_WIDTH; k++)
      begin
        if ((commit_i[k].valid || want[k].valid) && commit_i[k] !== want[k])
          report_mismatch($sformatf("commit_o[%0d]", k), commit_i[k], want[k]);
      end
      if (full_i !== (model_q.size() == DEPTH))
        report_mismatch("full_o", full_i, model_q.size() == DEPTH);
      if (empty_i !== (model_q.size() == 0))
        report_mismatch("empty_o", empty_i, model_q.size() == 0);
      if (alloc_idx_i !== model_tail)
        report_mismatch("alloc_idx_o", alloc_idx_i, model_tail);
    end
  end

endmodule

// ==== sim/tb_active_list.sv ====
`timescale 1ns/1ns

module tb_active_list
  import al_cfg_pkg::*;
  import al_types_pkg::*;
();

  localparam int DRAIN_LIMIT = 200;

  logic                               clk;
  logic                               reset;
  dispatch_t                          dispatch;
  complete_t [DEF_COMPLETE_WIDTH-1:0] complete;
  al_idx_t                            alloc_idx;
  commit_t   [DEF_COMMIT_WIDTH-1:0]   commit;
  logic                               full;
  logic                               empty;
  int                                 check_errors;
  int                                 timeout_errors;

  // indices dispatched but not yet completed
  al_idx_t pending [$];
  al_idx_t next_idx;

  active_list u_active_list (
    .clk         (clk),
    .reset       (reset),
    .dispatch_i  (dispatch),
    .complete_i  (complete),
    .alloc_idx_o (alloc_idx),
    .commit_o    (commit),
    .full_o      (full),
    .empty_o     (empty)
  );

  al_checker u_al_checker (
    .clk         (clk),
    .reset       (reset),
    .dispatch_i  (dispatch),
    .complete_i  (complete),
    .alloc_idx_i (alloc_idx),
    .commit_i    (commit),
    .full_i      (full),
    .empty_i     (empty),
    .errors_o    (check_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // one cycle of stimulus, 2 ns after the edge
  task automatic drive_cycle(input int disp_pct, input int comp_pct);
    int pick;
    @(posedge clk);
    #2;
    dispatch = '0;
    complete = '0;
    // only entries accepted at an earlier edge
    for (int w = 0; w < DEF_COMPLETE_WIDTH; w++)
    begin
      if (pending.size() > 0 && $urandom % 100 < comp_pct)
      begin
        pick              = $urandom % pending.size();
        complete[w].valid = 1'b1;
        complete[w].idx   = pending[pick];
        pending.delete(pick);
      end
    end
    // full is back-pressure, so no strobe then
    if (!full && $urandom % 100 < disp_pct)
    begin
      dispatch.valid   = 1'b1;
      dispatch.payload = {TAG_W'($urandom), PC_W'($urandom)};
      pending.push_back(next_idx);
      next_idx = al_idx_t'((int'(next_idx) + 1) % AL_DEPTH);
    end
  endtask

  initial
  begin
    int cycles;
    int assert_errors;
    void'($urandom(85701));
    reset          = 1'b1;
    dispatch       = '0;
    complete       = '0;
    next_idx       = '0;
    timeout_errors = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    // fill with no completions, list runs full
    repeat (AL_DEPTH + 4) drive_cycle(100, 0);
    // random mix, heavier dispatch in the first half
    for (int i = 0; i < 600; i++)
      drive_cycle((i < 300) ? 70 : 45, 30);
    // drain: complete whatever is left
    cycles = 0;
    do
    begin
      drive_cycle(0, 100);
      cycles++;
    end
    while (!empty && cycles < DRAIN_LIMIT);
    if (!empty)
    begin
      timeout_errors++;
      $display("timeout: list still not empty after %0d drain cycles", DRAIN_LIMIT);
    end
    repeat (2) drive_cycle(0, 0);
    assert_errors = u_active_list.u_al_ctrl.u_al_ctrl_asserts.fail_count;
    $display("errors: checker %0d, assertions %0d, timeouts %0d",
             check_errors, assert_errors, timeout_errors);
    if (check_errors + assert_errors + timeout_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== list.f ====
hw/al_cfg_pkg.sv
hw/al_types_pkg.sv
hw/al_ready_ram.sv
hw/al_payload_ram.sv
hw/al_ctrl.sv
hw/active_list.sv
sim/al_ctrl_asserts.sv
sim/al_checker.sv
sim/tb_active_list.sv
